// ==== rvv_isa_pkg.sv ====
package rvv_isa_pkg;

  // operand category of the OP-V major opcode
  typedef logic [2:0] funct3_t;

  localparam funct3_t OPIVV = 3'b000;
  localparam funct3_t OPMVV = 3'b010;
  localparam funct3_t OPIVI = 3'b011;
  localparam funct3_t OPIVX = 3'b100;
  localparam funct3_t OPMVX = 3'b110;

  typedef logic [5:0] funct6_t;

  localparam funct6_t VMINU      = 6'b000100;
  localparam funct6_t VMIN       = 6'b000101;
  localparam funct6_t VMAXU      = 6'b000110;
  localparam funct6_t VMAX       = 6'b000111;
  localparam funct6_t VMERGE_VMV = 6'b010111;
  localparam funct6_t VXUNARY0   = 6'b010010;
  localparam funct6_t VWXUNARY0  = 6'b010000;

  // vs1 field reused as a sub-opcode by the unary groups
  typedef logic [4:0] vs1_op_t;

  localparam vs1_op_t VZEXT_VF4 = 5'b00100;
  localparam vs1_op_t VSEXT_VF4 = 5'b00101;
  localparam vs1_op_t VZEXT_VF2 = 5'b00110;
  localparam vs1_op_t VSEXT_VF2 = 5'b00111;
  localparam vs1_op_t VMV_X_S   = 5'b00000;

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MINU,
    OP_MIN,
    OP_MAXU,
    OP_MAX,
    OP_MOVE,
    OP_MERGE,
    OP_ZEXT2,
    OP_SEXT2,
    OP_ZEXT4,
    OP_SEXT4,
    OP_MV_X_S,
    OP_MV_S_X
  } alu_op_e;

endpackage

// ==== alu_types_pkg.sv ====
package alu_types_pkg;

  localparam int XLEN        = 32;
  localparam int ROB_TAG_W   = 4;
  localparam int UOP_INDEX_W = 3;

  // element widths
  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [ROB_TAG_W-1:0]   rob_tag_t;
  typedef logic [UOP_INDEX_W-1:0] uop_index_t;

  typedef logic [BYTE_WIDTH-1:0]  elem8_t;
  typedef logic [HWORD_WIDTH-1:0] elem16_t;
  typedef logic [WORD_WIDTH-1:0]  elem32_t;

endpackage

// ==== uop_decode.sv ====
`timescale 1ns/1ps

module uop_decode import rvv_isa_pkg::*, alu_types_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    alu_uop_valid,
  input  funct3_t funct3,
  input  funct6_t funct6,
  input  vs1_op_t vs1_op,
  input  logic    vm,
  input  logic    vs1_data_valid,
  input  logic    vs2_data_valid,
  input  logic    rs1_data_valid,
  input  logic    v0_data_valid,
  input  eew_e    vs2_eew,
  output alu_op_e op,
  output logic    operands_ok
);

  logic scalar_form;
  logic src1_ok;

  // x and i forms take rs1 (or the immediate) instead of vs1
  assign scalar_form = funct3[2] | funct3[0];
  assign src1_ok     = scalar_form ? rs1_data_valid : vs1_data_valid;

  always_comb begin
    op = OP_NONE;
    case (funct3)
      OPIVV, OPIVX, OPIVI: begin
        case (funct6)
          VMINU: op = (funct3 != OPIVI) ? OP_MINU : OP_NONE;
          VMIN:  op = (funct3 != OPIVI) ? OP_MIN  : OP_NONE;
          VMAXU: op = (funct3 != OPIVI) ? OP_MAXU : OP_NONE;
          VMAX:  op = (funct3 != OPIVI) ? OP_MAX  : OP_NONE;
          VMERGE_VMV: op = vm ? OP_MOVE : OP_MERGE;
          default: op = OP_NONE;
        endcase
      end
      OPMVV: begin
        if (funct6 == VXUNARY0) begin
          case (vs1_op)
            VZEXT_VF2: op = OP_ZEXT2;
            VSEXT_VF2: op = OP_SEXT2;
            VZEXT_VF4: op = OP_ZEXT4;
            VSEXT_VF4: op = OP_SEXT4;
            default:   op = OP_NONE;
          endcase
        end else if (funct6 == VWXUNARY0 && vm && vs1_op == VMV_X_S) begin
          op = OP_MV_X_S;
        end
      end
      OPMVX: begin
        if (funct6 == VWXUNARY0 && vm) begin
          op = OP_MV_S_X;
        end
      end
      default: op = OP_NONE;
    endcase
  end

  always_comb begin
    case (op)
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX: operands_ok = src1_ok & vs2_data_valid;
      OP_MOVE:   operands_ok = src1_ok;
      OP_MERGE:  operands_ok = src1_ok & vs2_data_valid & v0_data_valid;
      // extensions read vs2 only, vs1 holds the sub-opcode
      OP_ZEXT2, OP_SEXT2: begin
        operands_ok = ~vs1_data_valid & vs2_data_valid & (vs2_eew inside {EEW8, EEW16});
      end
      OP_ZEXT4, OP_SEXT4: begin
        operands_ok = ~vs1_data_valid & vs2_data_valid & (vs2_eew == EEW8);
      end
      OP_MV_X_S: operands_ok = vs2_data_valid;
      OP_MV_S_X: operands_ok = rs1_data_valid;
      default:   operands_ok = 1'b0;
    endcase
  end

  // the issue queue should only send a recognised op once its operands are in
  a_op_has_operands : assert property (
    @(posedge clk) disable iff (!rst_n)
    (alu_uop_valid && op != OP_NONE) |-> operands_ok
  ) else $warning("%s issued without its operands, dropped", op.name());

endmodule

// ==== operand_prep.sv ====
`timescale 1ns/1ps

module operand_prep import rvv_isa_pkg::*, alu_types_pkg::*; #(
  parameter int VLEN = 128
) (
  input  alu_op_e           op,
  input  eew_e              vd_eew,
  input  eew_e              vs2_eew,
  input  uop_index_t        uop_index,
  input  logic [VLEN-1:0]   vs1_data,
  input  logic [VLEN-1:0]   vs2_data,
  input  logic [VLEN-1:0]   v0_data,
  input  xlen_t             rs1_data,
  input  logic              scalar_src,
  output logic [VLEN-1:0]   src1,
  output logic [VLEN-1:0]   src2,
  output logic [VLEN/8-1:0] mask_bits
);

  localparam int VLENB = VLEN / BYTE_WIDTH;

  eew_e            bcast_eew;
  logic [VLEN-1:0] rs1_bcast;

  // keep element 0 only, zeros above
  function automatic logic [VLEN-1:0] elem0(input eew_e eew, input logic [VLEN-1:0] data);
    logic [VLEN-1:0] res;
    res = '0;
    case (eew)
      EEW8:    res[BYTE_WIDTH-1:0]  = data[BYTE_WIDTH-1:0];
      EEW16:   res[HWORD_WIDTH-1:0] = data[HWORD_WIDTH-1:0];
      default: res[WORD_WIDTH-1:0]  = data[WORD_WIDTH-1:0];
    endcase
    return res;
  endfunction

  // vmv.v writes at vd width, all other users work at vs2 width
  assign bcast_eew = (op == OP_MOVE) ? vd_eew : vs2_eew;

  always_comb begin
    case (bcast_eew)
      EEW8:    rs1_bcast = {VLENB{rs1_data[BYTE_WIDTH-1:0]}};
      EEW16:   rs1_bcast = {(VLEN/HWORD_WIDTH){rs1_data[HWORD_WIDTH-1:0]}};
      default: rs1_bcast = {(VLEN/WORD_WIDTH){rs1_data}};
    endcase
  end

  always_comb begin
    src1 = '0;
    src2 = '0;
    case (op)
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX, OP_MERGE: begin
        src1 = scalar_src ? rs1_bcast : vs1_data;
        src2 = vs2_data;
      end
      OP_MOVE: src1 = scalar_src ? rs1_bcast : vs1_data;
      // chunk picked by uop index, repeated so every lane sees its element
      OP_ZEXT2, OP_SEXT2: src2 = {2{vs2_data[uop_index[0]*(VLEN/2) +: VLEN/2]}};
      OP_ZEXT4, OP_SEXT4: src2 = {4{vs2_data[uop_index[1:0]*(VLEN/4) +: VLEN/4]}};
      OP_MV_X_S: src2 = elem0(vs2_eew, vs2_data);
      OP_MV_S_X: src1 = elem0(vs2_eew, rs1_bcast);
      default: ;
    endcase
  end

  // v0 holds one bit per element over the whole register group
  always_comb begin
    mask_bits = '0;
    case (vs2_eew)
      EEW8:    mask_bits = v0_data[uop_index*VLENB +: VLENB];
      EEW16:   mask_bits[VLENB/2-1:0] = v0_data[uop_index*(VLENB/2) +: VLENB/2];
      default: mask_bits[VLENB/4-1:0] = v0_data[uop_index*(VLENB/4) +: VLENB/4];
    endcase
  end

endmodule

// ==== minmax_lanes.sv ====
`timescale 1ns/1ps

module minmax_lanes import rvv_isa_pkg::*, alu_types_pkg::*; #(
  parameter int VLEN = 128
) (
  input  alu_op_e         op,
  input  eew_e            vs2_eew,
  input  logic [VLEN-1:0] src1,
  input  logic [VLEN-1:0] src2,
  output logic [VLEN-1:0] minmax_data
);

  logic                  is_signed;
  logic                  pick_max;
  logic [2:0][VLEN-1:0]  lane_res;

  assign is_signed = (op == OP_MIN) || (op == OP_MAX);
  assign pick_max  = (op == OP_MAXU) || (op == OP_MAX);

  // one lane set per element width, 8/16/32
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = BYTE_WIDTH << w;

    for (genvar i = 0; i < VLEN/EW; i++) begin : g_elem
      logic signed [EW:0] a;
      logic signed [EW:0] b;
      logic               lt;

      // one extra bit, sign copy or zero, so one signed compare covers both
      assign a  = {is_signed & src2[i*EW+EW-1], src2[i*EW +: EW]};
      assign b  = {is_signed & src1[i*EW+EW-1], src1[i*EW +: EW]};
      assign lt = a < b;

      assign lane_res[w][i*EW +: EW] = (lt ^ pick_max) ? a[EW-1:0] : b[EW-1:0];
    end
  end

  always_comb begin
    case (vs2_eew)
      EEW8:    minmax_data = lane_res[0];
      EEW16:   minmax_data = lane_res[1];
      EEW32:   minmax_data = lane_res[2];
      default: minmax_data = '0;
    endcase
  end

endmodule

// ==== extend_lanes.sv ====
`timescale 1ns/1ps

module extend_lanes import rvv_isa_pkg::*, alu_types_pkg::*; #(
  parameter int VLEN = 128
) (
  input  alu_op_e         op,
  input  eew_e            vs2_eew,
  input  logic [VLEN-1:0] src2,
  output logic [VLEN-1:0] extend_data
);

  logic sgn;

  assign sgn = (op == OP_SEXT2) || (op == OP_SEXT4);

  for (genvar j = 0; j < VLEN/WORD_WIDTH; j++) begin : g_word
    elem8_t  b_lo;
    elem8_t  b_hi;
    elem16_t h;
    elem32_t word;

    // low half of src2 feeds the whole output, the chunk is already repeated
    assign b_lo = src2[(2*j)*BYTE_WIDTH +: BYTE_WIDTH];
    assign b_hi = src2[(2*j+1)*BYTE_WIDTH +: BYTE_WIDTH];
    assign h    = src2[j*HWORD_WIDTH +: HWORD_WIDTH];

    always_comb begin
      word = '0;
      case (op)
        OP_ZEXT2, OP_SEXT2: begin
          if (vs2_eew == EEW8) begin
            word = {{8{sgn & b_hi[7]}}, b_hi, {8{sgn & b_lo[7]}}, b_lo};
          end else if (vs2_eew == EEW16) begin
            word = {{16{sgn & h[15]}}, h};
          end
        end
        OP_ZEXT4, OP_SEXT4: begin
          if (vs2_eew == EEW8) begin
            word = {{24{sgn & src2[j*BYTE_WIDTH+7]}}, src2[j*BYTE_WIDTH +: BYTE_WIDTH]};
          end
        end
        default: ;
      endcase
    end

    assign extend_data[j*WORD_WIDTH +: WORD_WIDTH] = word;
  end

  // decode must never hand an eew32 source to a widening by two
  always_comb begin
    if (op == OP_ZEXT2 || op == OP_SEXT2) begin
      a_vf2_eew : assert (vs2_eew != EEW32) else $error("vf2 extend with eew32 source");
    end
  end

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ps

module result_stage import rvv_isa_pkg::*, alu_types_pkg::*; #(
  parameter int VLEN = 128
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_uop_valid,
  input  alu_op_e           op,
  input  logic              operands_ok,
  input  rob_tag_t          rob_entry,
  input  eew_e              vs2_eew,
  input  logic [VLEN-1:0]   src1,
  input  logic [VLEN-1:0]   src2,
  input  logic [VLEN/8-1:0] mask_bits,
  input  logic [VLEN-1:0]   minmax_data,
  input  logic [VLEN-1:0]   extend_data,
  output logic              result_valid,
  output rob_tag_t          result_rob_entry,
  output logic [VLEN-1:0]   result_data,
  output logic              result_ignore_vma
);

  localparam int VLENB = VLEN / BYTE_WIDTH;

  logic [VLENB-1:0] byte_sel;
  logic [VLEN-1:0]  merge_data;
  logic [VLEN-1:0]  sel_data;
  logic             accept;

  // spread the per-element mask bit over the bytes of each element
  for (genvar k = 0; k < VLENB; k++) begin : g_merge
    always_comb begin
      case (vs2_eew)
        EEW8:    byte_sel[k] = mask_bits[k];
        EEW16:   byte_sel[k] = mask_bits[k/2];
        default: byte_sel[k] = mask_bits[k/4];
      endcase
    end

    assign merge_data[k*BYTE_WIDTH +: BYTE_WIDTH] = byte_sel[k] ?
                                                    src1[k*BYTE_WIDTH +: BYTE_WIDTH] :
                                                    src2[k*BYTE_WIDTH +: BYTE_WIDTH];
  end

  always_comb begin
    case (op)
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX: sel_data = minmax_data;
      OP_MERGE:                         sel_data = merge_data;
      OP_MOVE, OP_MV_S_X:               sel_data = src1;
      OP_MV_X_S:                        sel_data = src2;
      OP_ZEXT2, OP_SEXT2, OP_ZEXT4, OP_SEXT4: sel_data = extend_data;
      default:                          sel_data = '0;
    endcase
  end

  assign accept = alu_uop_valid && operands_ok && (op != OP_NONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_rob_entry  <= rob_entry;
      result_data       <= sel_data;
      result_ignore_vma <= (op == OP_MERGE);
    end
  end

endmodule

// ==== alu_other_top.sv ====
`timescale 1ns/1ps

module alu_other_top import rvv_isa_pkg::*, alu_types_pkg::*; #(
  parameter int VLEN = 128
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            alu_uop_valid,
  input  rob_tag_t        rob_entry,
  input  funct6_t         funct6,
  input  funct3_t         funct3,
  input  logic            vm,
  input  vs1_op_t         vs1_op,
  input  logic [VLEN-1:0] vs1_data,
  input  logic            vs1_data_valid,
  input  logic [VLEN-1:0] vs2_data,
  input  logic            vs2_data_valid,
  input  xlen_t           rs1_data,
  input  logic            rs1_data_valid,
  input  logic [VLEN-1:0] v0_data,
  input  logic            v0_data_valid,
  input  eew_e            vd_eew,
  input  eew_e            vs2_eew,
  input  uop_index_t      uop_index,
  output logic            result_valid,
  output rob_tag_t        result_rob_entry,
  output logic [VLEN-1:0] result_data,
  output logic            result_ignore_vma
);

  alu_op_e           op;
  logic              operands_ok;
  logic              scalar_src;
  logic [VLEN-1:0]   src1;
  logic [VLEN-1:0]   src2;
  logic [VLEN/8-1:0] mask_bits;
  logic [VLEN-1:0]   minmax_data;
  logic [VLEN-1:0]   extend_data;

  // opivx, opmvx and opivi all carry a scalar or immediate in rs1
  assign scalar_src = funct3[2] | funct3[0];

  uop_decode u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_uop_valid  (alu_uop_valid),
    .funct3         (funct3),
    .funct6         (funct6),
    .vs1_op         (vs1_op),
    .vm             (vm),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data_valid (vs2_data_valid),
    .rs1_data_valid (rs1_data_valid),
    .v0_data_valid  (v0_data_valid),
    .vs2_eew        (vs2_eew),
    .op             (op),
    .operands_ok    (operands_ok)
  );

  operand_prep #(.VLEN(VLEN)) u_prep (
    .op         (op),
    .vd_eew     (vd_eew),
    .vs2_eew    (vs2_eew),
    .uop_index  (uop_index),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .v0_data    (v0_data),
    .rs1_data   (rs1_data),
    .scalar_src (scalar_src),
    .src1       (src1),
    .src2       (src2),
    .mask_bits  (mask_bits)
  );

  minmax_lanes #(.VLEN(VLEN)) u_minmax (
    .op          (op),
    .vs2_eew     (vs2_eew),
    .src1        (src1),
    .src2        (src2),
    .minmax_data (minmax_data)
  );

  extend_lanes #(.VLEN(VLEN)) u_extend (
    .op          (op),
    .vs2_eew     (vs2_eew),
    .src2        (src2),
    .extend_data (extend_data)
  );

  result_stage #(.VLEN(VLEN)) u_result (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_uop_valid     (alu_uop_valid),
    .op                (op),
    .operands_ok       (operands_ok),
    .rob_entry         (rob_entry),
    .vs2_eew           (vs2_eew),
    .src1              (src1),
    .src2              (src2),
    .mask_bits         (mask_bits),
    .minmax_data       (minmax_data),
    .extend_data       (extend_data),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

endmodule

// ==== tb_alu_model.svh ====
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

function automatic int eew_bits(input eew_e e);
  case (e)
    EEW8:    return 8;
    EEW16:   return 16;
    default: return 32;
  endcase
endfunction

function automatic logic [31:0] width_mask(input int ew);
  return (ew >= 32) ? 32'hffff_ffff : ((32'h1 << ew) - 32'h1);
endfunction

function automatic logic [31:0] get_elem(input logic [VLEN-1:0] data, input int ew, input int i);
  logic [VLEN-1:0] sh;
  sh = data >> (i * ew);
  return sh[31:0] & width_mask(ew);
endfunction

// sign of an ew-bit element carried into 32 bits
function automatic logic signed [31:0] sext(input logic [31:0] v, input int ew);
  logic signed [31:0] t;
  t = $signed(v << (32 - ew));
  return t >>> (32 - ew);
endfunction

function automatic logic is_scalar_form(input funct3_t f3);
  return (f3 == OPIVX) || (f3 == OPIVI) || (f3 == OPMVX);
endfunction

function automatic alu_op_e model_op(input funct3_t f3, input funct6_t f6, input vs1_op_t v1,
                                     input logic vm);
  if (f3 == OPIVV || f3 == OPIVX) begin
    if (f6 == VMINU) return OP_MINU;
    if (f6 == VMIN) return OP_MIN;
    if (f6 == VMAXU) return OP_MAXU;
    if (f6 == VMAX) return OP_MAX;
  end
  if ((f3 == OPIVV || f3 == OPIVX || f3 == OPIVI) && f6 == VMERGE_VMV) begin
    return vm ? OP_MOVE : OP_MERGE;
  end
  if (f3 == OPMVV && f6 == VXUNARY0) begin
    if (v1 == VZEXT_VF2) return OP_ZEXT2;
    if (v1 == VSEXT_VF2) return OP_SEXT2;
    if (v1 == VZEXT_VF4) return OP_ZEXT4;
    if (v1 == VSEXT_VF4) return OP_SEXT4;
  end
  if (f3 == OPMVV && f6 == VWXUNARY0 && vm && v1 == VMV_X_S) return OP_MV_X_S;
  if (f3 == OPMVX && f6 == VWXUNARY0 && vm) return OP_MV_S_X;
  return OP_NONE;
endfunction

function automatic logic model_ok(input alu_op_e op, input logic scalar, input logic v1_ok,
                                  input logic v2_ok, input logic r1_ok, input logic v0_ok,
                                  input eew_e e2);
  logic src_ok;
  src_ok = scalar ? r1_ok : v1_ok;
  case (op)
    OP_MINU, OP_MIN, OP_MAXU, OP_MAX: return src_ok && v2_ok;
    OP_MOVE:            return src_ok;
    OP_MERGE:           return src_ok && v2_ok && v0_ok;
    OP_ZEXT2, OP_SEXT2: return !v1_ok && v2_ok && (e2 == EEW8 || e2 == EEW16);
    OP_ZEXT4, OP_SEXT4: return !v1_ok && v2_ok && (e2 == EEW8);
    OP_MV_X_S:          return v2_ok;
    OP_MV_S_X:          return r1_ok;
    default:            return 1'b0;
  endcase
endfunction

function automatic logic [VLEN-1:0] model_data(input alu_op_e op, input logic scalar,
                                               input eew_e vd_e, input eew_e s2_e,
                                               input uop_index_t idx,
                                               input logic [VLEN-1:0] vs1,
                                               input logic [VLEN-1:0] vs2,
                                               input logic [VLEN-1:0] v0,
                                               input xlen_t rs1);
  logic [VLEN-1:0] res;
  logic [31:0]     a;
  logic [31:0]     b;
  logic [31:0]     r;
  int              ew;
  int              n;
  int              i;
  int              fac;
  int              base;
  res = '0;
  ew  = eew_bits((op == OP_MOVE) ? vd_e : s2_e);
  n   = VLEN / ew;
  case (op)
    OP_MINU, OP_MIN, OP_MAXU, OP_MAX, OP_MERGE, OP_MOVE: begin
      for (i = 0; i < n; i++) begin
        a = get_elem(vs2, ew, i);
        b = scalar ? (rs1 & width_mask(ew)) : get_elem(vs1, ew, i);
        case (op)
          OP_MINU:  r = (a < b) ? a : b;
          OP_MAXU:  r = (a > b) ? a : b;
          OP_MIN:   r = (sext(a, ew) < sext(b, ew)) ? a : b;
          OP_MAX:   r = (sext(a, ew) > sext(b, ew)) ? a : b;
          // one v0 bit per element, this uop's slice of the group
          OP_MERGE: r = v0[idx * n + i] ? b : a;
          default:  r = b;
        endcase
        res |= VLEN'(r) << (i * ew);
      end
    end
    OP_ZEXT2, OP_SEXT2, OP_ZEXT4, OP_SEXT4: begin
      fac  = (op == OP_ZEXT2 || op == OP_SEXT2) ? 2 : 4;
      n    = VLEN / (ew * fac);
      base = (idx % fac) * n;
      for (i = 0; i < n; i++) begin
        a = get_elem(vs2, ew, base + i);
        r = (op == OP_SEXT2 || op == OP_SEXT4) ? sext(a, ew) : a;
        res |= VLEN'(r & width_mask(ew * fac)) << (i * ew * fac);
      end
    end
    OP_MV_X_S: res = VLEN'(get_elem(vs2, ew, 0));
    OP_MV_S_X: res = VLEN'(rs1 & width_mask(ew));
    default:   res = '0;
  endcase
  return res;
endfunction

`endif

// ==== tb_alu_other.sv ====
`timescale 1ns/1ps

module tb_alu_other import rvv_isa_pkg::*, alu_types_pkg::*; ();

  localparam int VLEN        = 128;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_UOPS    = 2000;
  localparam int WATCHDOG_NS = NUM_UOPS * CLK_PERIOD + 100;

  typedef struct packed {
    logic [31:0]     num;
    alu_op_e         op;
    rob_tag_t        tag;
    logic [VLEN-1:0] data;
    logic            vma;
  } expect_t;

  logic            clk;
  logic            rst_n;
  logic            alu_uop_valid;
  rob_tag_t        rob_entry;
  funct6_t         funct6;
  funct3_t         funct3;
  logic            vm;
  vs1_op_t         vs1_op;
  logic [VLEN-1:0] vs1_data;
  logic            vs1_data_valid;
  logic [VLEN-1:0] vs2_data;
  logic            vs2_data_valid;
  xlen_t           rs1_data;
  logic            rs1_data_valid;
  logic [VLEN-1:0] v0_data;
  logic            v0_data_valid;
  eew_e            vd_eew;
  eew_e            vs2_eew;
  uop_index_t      uop_index;
  logic            result_valid;
  rob_tag_t        result_rob_entry;
  logic [VLEN-1:0] result_data;
  logic            result_ignore_vma;

  int      seed;
  int      err_count;
  int      check_count;
  int      accept_count;
  expect_t exp_q[$];

  `include "tb_alu_model.svh"

  alu_other_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_uop_valid     (alu_uop_valid),
    .rob_entry         (rob_entry),
    .funct6            (funct6),
    .funct3            (funct3),
    .vm                (vm),
    .vs1_op            (vs1_op),
    .vs1_data          (vs1_data),
    .vs1_data_valid    (vs1_data_valid),
    .vs2_data          (vs2_data),
    .vs2_data_valid    (vs2_data_valid),
    .rs1_data          (rs1_data),
    .rs1_data_valid    (rs1_data_valid),
    .v0_data           (v0_data),
    .v0_data_valid     (v0_data_valid),
    .vd_eew            (vd_eew),
    .vs2_eew           (vs2_eew),
    .uop_index         (uop_index),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [VLEN-1:0] rand_vec();
    logic [VLEN-1:0] v;
    int              k;
    v = '0;
    for (k = 0; k < VLEN / 32; k++) begin
      v[k*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  task automatic check_data(input string name, input logic [VLEN-1:0] exp,
                            input logic [VLEN-1:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic drive_idle();
    alu_uop_valid  = 1'b0;
    rob_entry      = '0;
    funct6         = '0;
    funct3         = '0;
    vm             = 1'b0;
    vs1_op         = '0;
    vs1_data       = '0;
    vs1_data_valid = 1'b0;
    vs2_data       = '0;
    vs2_data_valid = 1'b0;
    rs1_data       = '0;
    rs1_data_valid = 1'b0;
    v0_data        = '0;
    v0_data_valid  = 1'b0;
    vd_eew         = EEW8;
    vs2_eew        = EEW8;
    uop_index      = '0;
  endtask

  task automatic drive_uop(input int num);
    int unsigned pick;
    alu_op_e     op;
    logic        scalar;
    expect_t     e;
    pick           = rand_below(100);
    alu_uop_valid  = (rand_below(10) != 0);
    rob_entry      = rob_tag_t'(rand_below(16));
    vm             = (rand_below(2) == 1);
    vs1_op         = vs1_op_t'(rand_below(32));
    vs1_data       = rand_vec();
    vs2_data       = rand_vec();
    v0_data        = rand_vec();
    rs1_data       = $random(seed);
    vd_eew         = eew_e'(rand_below(3));
    vs2_eew        = eew_e'(rand_below(3));
    uop_index      = uop_index_t'(rand_below(8));
    vs1_data_valid = 1'b1;
    vs2_data_valid = 1'b1;
    rs1_data_valid = 1'b1;
    v0_data_valid  = 1'b1;
    if (pick < 40) begin
      funct3 = (rand_below(2) == 0) ? OPIVV : OPIVX;
      funct6 = VMINU + funct6_t'(rand_below(4));
    end else if (pick < 55) begin
      funct3 = (pick < 45) ? OPIVV : ((pick < 50) ? OPIVX : OPIVI);
      funct6 = VMERGE_VMV;
    end else if (pick < 75) begin
      funct3         = OPMVV;
      funct6         = VXUNARY0;
      vs1_data_valid = 1'b0;
      case (rand_below(4))
        0:       vs1_op = VZEXT_VF2;
        1:       vs1_op = VSEXT_VF2;
        2:       vs1_op = VZEXT_VF4;
        default: vs1_op = VSEXT_VF4;
      endcase
      // eew32 is never legal for vf2, eew8 only for vf4
      if (vs1_op == VZEXT_VF2 || vs1_op == VSEXT_VF2) begin
        vs2_eew = (rand_below(2) == 0) ? EEW8 : EEW16;
      end else begin
        vs2_eew = EEW8;
      end
    end else if (pick < 85) begin
      funct3 = OPMVV;
      funct6 = VWXUNARY0;
      vm     = 1'b1;
      vs1_op = VMV_X_S;
    end else if (pick < 95) begin
      funct3 = OPMVX;
      funct6 = VWXUNARY0;
      vm     = 1'b1;
    end else begin
      funct3 = OPIVV;
      funct6 = {2'b11, 4'(rand_below(16))};
    end
    // flip one operand valid now and then
    if (rand_below(8) == 0) begin
      case (rand_below(4))
        0:       vs1_data_valid = ~vs1_data_valid;
        1:       vs2_data_valid = 1'b0;
        2:       rs1_data_valid = 1'b0;
        default: v0_data_valid  = 1'b0;
      endcase
    end
    scalar = is_scalar_form(funct3);
    op     = model_op(funct3, funct6, vs1_op, vm);
    if (alu_uop_valid && op != OP_NONE &&
        model_ok(op, scalar, vs1_data_valid, vs2_data_valid, rs1_data_valid,
                 v0_data_valid, vs2_eew)) begin
      e.num  = num;
      e.op   = op;
      e.tag  = rob_entry;
      e.vma  = (op == OP_MERGE);
      e.data = model_data(op, scalar, vd_eew, vs2_eew, uop_index, vs1_data, vs2_data,
                          v0_data, rs1_data);
      exp_q.push_back(e);
      accept_count++;
    end
  endtask

  task automatic check_result();
    expect_t e;
    alu_op_e op;
    string   name;
    if (exp_q.size() > 0) begin
      e    = exp_q.pop_front();
      op   = e.op;
      name = $sformatf("uop %0d %s", e.num, op.name());
      check_flag({name, " result_valid"}, 1'b1, result_valid);
      if (result_valid === 1'b1) begin
        check_tag({name, " rob_entry"}, e.tag, result_rob_entry);
        check_data({name, " data"}, e.data, result_data);
        check_flag({name, " ignore_vma"}, e.vma, result_ignore_vma);
      end
    end else if (result_valid !== 1'b0) begin
      err_count++;
      $display("result_valid was high at %0t ns with no micro-op pending", $time);
    end
  endtask

  initial begin
    int n;
    seed         = 32'hf58;
    err_count    = 0;
    check_count  = 0;
    accept_count = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    drive_idle();
    repeat (3) begin
      @(posedge clk);
      #1;
      check_flag("reset result_valid", 1'b0, result_valid);
    end
    rst_n = 1'b1;
    for (n = 0; n < NUM_UOPS; n++) begin
      drive_uop(n);
      @(posedge clk);
      #1;
      check_result();
    end
    drive_idle();
    @(posedge clk);
    #1;
    check_result();
    $display("micro-ops %0d, accepted %0d, checks %0d, errors %0d",
             NUM_UOPS, accept_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before all micro-ops were checked", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
rvv_isa_pkg.sv
alu_types_pkg.sv
uop_decode.sv
operand_prep.sv
minmax_lanes.sv
extend_lanes.sv
result_stage.sv
alu_other_top.sv
tb_alu_other.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_alu_other \
  -f src.f -o tb_alu_other &&
./obj_dir/tb_alu_other | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
